// File: loader_cfg.svh
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// UART bit time in HCLK cycles, short for simulation
`define LOADER_CLKS_PER_BIT 8

`define LOADER_RAM_WORDS 1024

// Bit 28 set selects the status block
`define LOADER_STATUS_BASE 32'h1000_0000

`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

`define HSIZE_BYTE 3'b000
`define HSIZE_WORD 3'b010

`endif

// File: loader_pkg.sv
package loader_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;

    typedef struct packed {
        addr_t       haddr;
        logic [1:0]  htrans;
        logic        hwrite;
        logic [2:0]  hsize;
        data_t       hwdata;
    } ahb_req_t;

    typedef struct packed {
        data_t hrdata;
        logic  hready;
        logic  hresp;
    } ahb_resp_t;

    typedef struct packed {
        addr_t addr;
        byte_t data;
        logic  valid;
    } load_write_t;

    typedef struct packed {
        logic  in_progress;
        logic  format_error;
        logic  checksum_error;
        byte_t error_location;   // Record number of the failure
    } load_status_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    typedef enum logic [2:0] {
        SREC_WAIT_S,
        SREC_TYPE,
        SREC_COUNT,
        SREC_ADDR,
        SREC_DATA,
        SREC_SUM,
        SREC_EOL
    } srec_state_t;

endpackage

// File: uart_receiver.sv
`timescale 1ns/1ns
`include "loader_cfg.svh"

module uart_receiver import loader_pkg::*; (
    input  logic  HCLK,
    input  logic  rst_n,
    input  logic  rx,
    output byte_t rx_byte,
    output logic  rx_valid
);

    uart_state_t state;
    logic [1:0]  rx_sync;
    logic        rx_s;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic        bit_end;

    assign rx_s    = rx_sync[1];
    assign bit_end = cnt == 16'(`LOADER_CLKS_PER_BIT - 1);

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;   // Line idles high
            state    <= UART_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                UART_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (cnt == 16'(`LOADER_CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? UART_IDLE : UART_DATA;   // Glitch check
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state    <= UART_IDLE;
                        rx_valid <= rx_s;   // Framing error drops the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (state == UART_DATA && bit_end) begin
            rx_byte <= {rx_s, rx_byte[7:1]};   // LSB first
        end
    end

endmodule

// File: srec_parser.sv
`timescale 1ns/1ns

module srec_parser import loader_pkg::*; (
    input  logic         HCLK,
    input  logic         rst_n,
    input  byte_t        rx_byte,
    input  logic         rx_valid,
    input  logic         load_enable,
    output load_write_t  write,
    output load_status_t status
);

    srec_state_t state;
    logic        half;        // High nibble captured
    logic [3:0]  hi_nib;
    logic [3:0]  nib;
    logic        is_hex;
    byte_t       byte_val;
    logic        hex_state;
    logic        pair_done;
    logic        fmt_err;
    logic        is_data;     // S1 or S3
    logic        is_end;      // S7 or S9
    logic [2:0]  addr_len;
    logic [2:0]  addr_left;
    byte_t       left;        // Bytes still due in this record
    byte_t       sum;
    byte_t       rec_num;
    addr_t       addr;

    always_comb begin
        is_hex = 1'b1;
        nib    = rx_byte[3:0];
        if (rx_byte inside {["A":"F"], ["a":"f"]}) begin
            nib = rx_byte[3:0] + 4'd9;
        end else if (!(rx_byte inside {["0":"9"]})) begin
            is_hex = 1'b0;
        end
    end

    assign byte_val  = {hi_nib, nib};
    assign hex_state = state inside {SREC_COUNT, SREC_ADDR, SREC_DATA, SREC_SUM};
    assign pair_done = rx_valid && hex_state && is_hex && half;

    always_comb begin
        fmt_err = 1'b0;
        if (rx_valid) begin
            case (state)
                SREC_TYPE: fmt_err = !(rx_byte inside {"0", "1", "3", "7", "9"});
                SREC_EOL:  fmt_err = !(rx_byte inside {"S", 8'h0d, 8'h0a});
                default:   fmt_err = hex_state && !is_hex;
            endcase
        end
        // Count must cover address and checksum
        if (pair_done && state == SREC_COUNT && byte_val <= byte_t'(addr_len)) begin
            fmt_err = 1'b1;
        end
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            state     <= SREC_WAIT_S;
            half      <= 1'b0;
            hi_nib    <= '0;
            is_data   <= 1'b0;
            is_end    <= 1'b0;
            addr_len  <= '0;
            addr_left <= '0;
            left      <= '0;
            sum       <= '0;
            rec_num   <= '0;
            addr      <= '0;
            write     <= '0;
            status    <= '0;
        end else begin
            write.valid <= 1'b0;
            if (rx_valid && hex_state && is_hex) begin
                hi_nib <= nib;
                half   <= !half;
            end
            if (fmt_err) begin
                state                 <= SREC_WAIT_S;
                half                  <= 1'b0;
                status.in_progress    <= 1'b0;
                status.format_error   <= 1'b1;
                status.error_location <= rec_num;
            end else if (rx_valid) begin
                case (state)
                    SREC_WAIT_S: begin
                        if (rx_byte == "S" && load_enable) begin
                            state   <= SREC_TYPE;
                            status  <= '{in_progress: 1'b1, default: '0};   // Clears old errors
                            rec_num <= '0;
                        end
                    end
                    SREC_TYPE: begin
                        is_data  <= rx_byte inside {"1", "3"};
                        is_end   <= rx_byte inside {"7", "9"};
                        addr_len <= (rx_byte inside {"3", "7"}) ? 3'd4 : 3'd2;
                        state    <= SREC_COUNT;
                    end
                    SREC_COUNT: begin
                        if (pair_done) begin
                            left      <= byte_val;
                            sum       <= byte_val;
                            addr      <= '0;
                            addr_left <= addr_len;
                            state     <= SREC_ADDR;
                        end
                    end
                    SREC_ADDR: begin
                        if (pair_done) begin
                            addr      <= {addr[23:0], byte_val};
                            sum       <= sum + byte_val;
                            left      <= left - 1'b1;
                            addr_left <= addr_left - 1'b1;
                            if (addr_left == 3'd1) begin
                                state <= (left == 8'd2) ? SREC_SUM : SREC_DATA;
                            end
                        end
                    end
                    SREC_DATA: begin
                        if (pair_done) begin
                            write.valid <= is_data;   // S0 payload is dropped
                            write.addr  <= addr;
                            write.data  <= byte_val;
                            addr        <= addr + 1'b1;
                            sum         <= sum + byte_val;
                            left        <= left - 1'b1;
                            if (left == 8'd2) begin
                                state <= SREC_SUM;
                            end
                        end
                    end
                    SREC_SUM: begin
                        if (pair_done) begin
                            if (byte_val != ~sum) begin
                                state                 <= SREC_WAIT_S;
                                status.in_progress    <= 1'b0;
                                status.checksum_error <= 1'b1;
                                status.error_location <= rec_num;
                            end else if (is_end) begin
                                state              <= SREC_WAIT_S;
                                status.in_progress <= 1'b0;
                            end else begin
                                rec_num <= rec_num + 1'b1;
                                state   <= SREC_EOL;
                            end
                        end
                    end
                    SREC_EOL: begin
                        if (rx_byte == "S") begin
                            state <= SREC_TYPE;
                        end
                    end
                    default: state <= SREC_WAIT_S;
                endcase
            end
        end
    end

endmodule

// File: ahb_matrix.sv
`timescale 1ns/1ns
`include "loader_cfg.svh"

module ahb_matrix import loader_pkg::*; (
    input  logic        HCLK,
    input  logic        rst_n,
    input  ahb_req_t    ext_req,
    input  load_write_t write,
    input  logic        in_progress,
    input  ahb_resp_t   ram_resp,
    input  ahb_resp_t   regs_resp,
    output ahb_req_t    ram_req,
    output ahb_req_t    regs_req,
    output logic        ram_hsel,
    output logic        regs_hsel,
    output ahb_resp_t   ext_resp
);

    ahb_req_t ldr_req;
    ahb_req_t bus_req;
    data_t    ldr_wdata;
    logic     ldr_owner_q;   // Loader owned the last address phase
    logic     sel_regs;
    logic     sel_regs_q;

    always_ff @(posedge HCLK) begin
        ldr_wdata <= data_t'(write.data) << {write.addr[1:0], 3'b000};   // Byte lane
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            ldr_owner_q <= 1'b0;
            sel_regs_q  <= 1'b0;
        end else begin
            ldr_owner_q <= in_progress;
            sel_regs_q  <= sel_regs;
        end
    end

    always_comb begin
        ldr_req.haddr  = write.addr;
        ldr_req.htrans = write.valid ? `HTRANS_NONSEQ : `HTRANS_IDLE;
        ldr_req.hwrite = write.valid;
        ldr_req.hsize  = `HSIZE_BYTE;
        ldr_req.hwdata = ldr_wdata;
        bus_req        = in_progress ? ldr_req : ext_req;   // External master shut out
        bus_req.hwdata = ldr_owner_q ? ldr_req.hwdata : ext_req.hwdata;
    end

    assign sel_regs  = (bus_req.haddr & `LOADER_STATUS_BASE) != '0;
    assign regs_hsel = sel_regs;
    assign ram_hsel  = !sel_regs;
    assign ram_req   = bus_req;
    assign regs_req  = bus_req;
    assign ext_resp  = sel_regs_q ? regs_resp : ram_resp;

endmodule

// File: ahb_ram.sv
`timescale 1ns/1ns
`include "loader_cfg.svh"

module ahb_ram import loader_pkg::*; (
    input  logic      HCLK,
    input  logic      hsel,
    input  ahb_req_t  req,
    output ahb_resp_t resp
);

    data_t      mem [0:`LOADER_RAM_WORDS-1];
    logic       wr_q;
    logic [9:0] idx_q;
    logic [1:0] off_q;
    logic [2:0] size_q;
    logic [3:0] lanes;

    always_ff @(posedge HCLK) begin
        wr_q   <= hsel && req.htrans == `HTRANS_NONSEQ && req.hwrite;
        idx_q  <= req.haddr[11:2];
        off_q  <= req.haddr[1:0];
        size_q <= req.hsize;
    end

    // Only byte and word sizes are in use
    assign lanes = (size_q == `HSIZE_BYTE) ? 4'b0001 << off_q : 4'b1111;

    always_ff @(posedge HCLK) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_q && lanes[i]) begin
                mem[idx_q][8*i +: 8] <= req.hwdata[8*i +: 8];
            end
        end
    end

    assign resp.hrdata = mem[idx_q];
    assign resp.hready = 1'b1;
    assign resp.hresp  = 1'b0;   // OKAY

endmodule

// File: loader_status_regs.sv
`timescale 1ns/1ns
`include "loader_cfg.svh"

module loader_status_regs import loader_pkg::*; (
    input  logic         HCLK,
    input  logic         rst_n,
    input  logic         hsel,
    input  ahb_req_t     req,
    input  load_status_t status,
    output ahb_resp_t    resp,
    output logic         load_enable
);

    logic wr_q;   // Write address phase seen

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wr_q        <= 1'b0;
            load_enable <= 1'b1;
        end else begin
            wr_q <= hsel && req.htrans == `HTRANS_NONSEQ && req.hwrite;
            if (wr_q) begin
                load_enable <= req.hwdata[16];   // Only writable bit
            end
        end
    end

    assign resp.hrdata = {
        15'b0,
        load_enable,
        status.error_location,
        5'b0,
        status.checksum_error,
        status.format_error,
        status.in_progress
    };
    assign resp.hready = 1'b1;
    assign resp.hresp  = 1'b0;

endmodule

// File: soc_top.sv
`timescale 1ns/1ns

module soc_top import loader_pkg::*; (
    input  logic       HCLK,
    input  logic       rst_n,
    input  addr_t      haddr,
    input  logic [1:0] htrans,
    input  logic       hwrite,
    input  logic [2:0] hsize,
    input  data_t      hwdata,
    output data_t      hrdata,
    output logic       hready,
    output logic       hresp,
    input  logic       uart_rx,
    output logic       soc_reset
);

    byte_t        rx_byte;
    logic         rx_valid;
    load_write_t  write;
    load_status_t status;
    logic         load_enable;
    ahb_req_t     ext_req;
    ahb_req_t     ram_req;
    ahb_req_t     regs_req;
    ahb_resp_t    ext_resp;
    ahb_resp_t    ram_resp;
    ahb_resp_t    regs_resp;
    logic         ram_hsel;
    logic         regs_hsel;

    assign ext_req = '{haddr: haddr, htrans: htrans, hwrite: hwrite,
                       hsize: hsize, hwdata: hwdata};
    assign hrdata    = ext_resp.hrdata;
    assign hready    = ext_resp.hready;
    assign hresp     = ext_resp.hresp;
    assign soc_reset = status.in_progress;   // CPU held during a load

    uart_receiver uart_receiver_i (
        .HCLK     (HCLK),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    srec_parser srec_parser_i (
        .HCLK        (HCLK),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .load_enable (load_enable),
        .write       (write),
        .status      (status)
    );

    loader_status_regs loader_status_regs_i (
        .HCLK        (HCLK),
        .rst_n       (rst_n),
        .hsel        (regs_hsel),
        .req         (regs_req),
        .status      (status),
        .resp        (regs_resp),
        .load_enable (load_enable)
    );

    ahb_matrix ahb_matrix_i (
        .HCLK        (HCLK),
        .rst_n       (rst_n),
        .ext_req     (ext_req),
        .write       (write),
        .in_progress (status.in_progress),
        .ram_resp    (ram_resp),
        .regs_resp   (regs_resp),
        .ram_req     (ram_req),
        .regs_req    (regs_req),
        .ram_hsel    (ram_hsel),
        .regs_hsel   (regs_hsel),
        .ext_resp    (ext_resp)
    );

    ahb_ram ahb_ram_i (
        .HCLK (HCLK),
        .hsel (ram_hsel),
        .req  (ram_req),
        .resp (ram_resp)
    );

endmodule

// File: tb_soc_top.sv
`timescale 1ns/1ns
`include "loader_cfg.svh"

module tb_soc_top import loader_pkg::*; ();

    logic       HCLK;
    logic       rst_n;
    addr_t      haddr;
    logic [1:0] htrans;
    logic       hwrite;
    logic [2:0] hsize;
    data_t      hwdata;
    data_t      hrdata;
    logic       hready;
    logic       hresp;
    logic       uart_rx;
    logic       soc_reset;

    byte_t       model_mem [0:4095];   // Byte image of the RAM
    byte_t       line_q [$];           // Characters of one record line
    byte_t       data_buf [0:15];
    logic [31:0] lcg_state;
    int          errors;
    int          reset_cycles = 0;
    logic        exp_en;
    logic        exp_fmt;
    logic        exp_cks;
    byte_t       exp_loc;

    soc_top dut_i (
        .HCLK      (HCLK),
        .rst_n     (rst_n),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hwdata    (hwdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp),
        .uart_rx   (uart_rx),
        .soc_reset (soc_reset)
    );

    always #4 HCLK = ~HCLK;

    always @(negedge HCLK) begin
        if (soc_reset === 1'b1) begin
            reset_cycles++;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;   // Low bits of an LCG are weak
    endfunction

    function automatic data_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic byte_t hex_char(input logic [3:0] nib, input logic lower);
        if (nib < 4'd10) begin
            return 8'h30 + 8'(nib);
        end
        return (lower ? 8'h61 : 8'h41) + 8'(nib) - 8'd10;
    endfunction

    // Register layout of the loader status word
    function automatic data_t status_word();
        return {15'b0, exp_en, exp_loc, 5'b0, exp_cks, exp_fmt, 1'b0};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("error %0t: %s: read %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge HCLK);
        while (hready !== 1'b1 && n < 16) begin
            @(negedge HCLK);
            n++;
        end
        if (hready !== 1'b1) begin
            $display("Timeout: the AHB data phase did not complete at %0t", $time);
            errors++;
        end
        check(hresp, 1'b0, "hresp in data phase");   // Always OKAY
    endtask

    task automatic wait_soc_reset(input logic level, input string what);
        int n;
        n = 0;
        @(negedge HCLK);
        while (soc_reset !== level && n < 400) begin
            @(negedge HCLK);
            n++;
        end
        if (soc_reset !== level) begin
            $display("Timeout: soc_reset did not go to %0d (%s) at %0t", level, what, $time);
            errors++;
        end
    endtask

    task automatic ahb_write(input addr_t addr, input data_t data, input logic [2:0] size);
        @(posedge HCLK);
        haddr  <= addr;
        htrans <= `HTRANS_NONSEQ;
        hwrite <= 1'b1;
        hsize  <= size;
        @(posedge HCLK);
        htrans <= `HTRANS_IDLE;   // Data phase
        hwrite <= 1'b0;
        hwdata <= data;
        wait_ready();
    endtask

    task automatic ahb_read(input addr_t addr, output data_t data);
        @(posedge HCLK);
        haddr  <= addr;
        htrans <= `HTRANS_NONSEQ;
        hwrite <= 1'b0;
        hsize  <= `HSIZE_WORD;
        @(posedge HCLK);
        htrans <= `HTRANS_IDLE;
        wait_ready();
        data = hrdata;
    endtask

    task automatic store_word(input addr_t a, input data_t d);
        ahb_write(a, d, `HSIZE_WORD);
        for (int b = 0; b < 4; b++) begin
            model_mem[int'(a[11:0]) + b] = d[8*b +: 8];
        end
    endtask

    task automatic check_status(input string what);
        data_t d;
        ahb_read(`LOADER_STATUS_BASE, d);
        check(d, status_word(), what);
    endtask

    task automatic verify_ram(input string what);
        data_t d;
        data_t exp;
        for (int w = 0; w < `LOADER_RAM_WORDS; w++) begin
            ahb_read(addr_t'(w * 4), d);
            exp = {model_mem[4*w+3], model_mem[4*w+2], model_mem[4*w+1], model_mem[4*w]};
            check(d, exp, $sformatf("%s, RAM word %0d", what, w));
        end
    endtask

    // 8N1 frame sent LSB first
    task automatic send_char(input byte_t c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge HCLK);
            uart_rx <= frame[i];
            repeat (`LOADER_CLKS_PER_BIT - 1) @(posedge HCLK);
        end
    endtask

    task automatic send_line(input int from);
        for (int i = from; i < line_q.size(); i++) begin
            send_char(line_q[i]);
        end
    endtask

    task automatic random_data(input int len);
        for (int i = 0; i < len; i++) begin
            data_buf[i] = byte_t'(next_rand());
        end
    endtask

    function automatic addr_t random_addr(input int len);
        return addr_t'(next_rand() % (4096 - len));
    endfunction

    // A new load start clears the error flags
    task automatic load_started();
        if (exp_en) begin
            exp_fmt = 1'b0;
            exp_cks = 1'b0;
            exp_loc = '0;
        end
    endtask

    task automatic build_record(input byte_t rtype, input addr_t addr, input int len,
                                input logic bad_sum, input int bad_pos);
        byte_t       bin [$];
        byte_t       sum;
        int          alen;
        int          pos;
        logic [31:0] r;
        alen = (rtype == "3" || rtype == "7") ? 4 : 2;
        r    = next_rand();
        bin.push_back(byte_t'(alen + len + 1));
        for (int i = alen - 1; i >= 0; i--) begin
            bin.push_back(addr[8*i +: 8]);
        end
        for (int i = 0; i < len; i++) begin
            bin.push_back(data_buf[i]);
        end
        sum = '0;
        foreach (bin[i]) begin
            sum += bin[i];
        end
        bin.push_back(~sum ^ {7'b0, bad_sum});
        line_q = {};
        line_q.push_back("S");
        line_q.push_back(rtype);
        foreach (bin[i]) begin
            line_q.push_back(hex_char(bin[i][7:4], r[0]));   // Mixed case digits
            line_q.push_back(hex_char(bin[i][3:0], r[0]));
        end
        if (bad_pos >= 0) begin
            line_q[bad_pos] = "G";
        end
        line_q.push_back(8'h0d);
        line_q.push_back(8'h0a);
        // A data byte lands once both of its digits arrive before any bad character
        if (exp_en && (rtype == "1" || rtype == "3")) begin
            for (int i = 0; i < len; i++) begin
                pos = 4 + 2 * alen + 2 * i;
                if (bad_pos < 0 || pos + 1 < bad_pos) begin
                    model_mem[(int'(addr) + i) % 4096] = data_buf[i];
                end
            end
        end
    endtask

    task automatic good_records(input byte_t rtype, input int count);
        int len;
        for (int r = 0; r < count; r++) begin
            len = 1 + int'(next_rand() % 16);
            random_data(len);
            build_record(rtype, random_addr(len), len, 1'b0, -1);
            send_line(0);
        end
    endtask

    task automatic random_load(input int records);
        load_started();
        good_records("3", records);
        build_record("7", 32'h0, 0, 1'b0, -1);
        send_line(0);
        wait_soc_reset(1'b0, "end of load");
    endtask

    initial begin
        data_t d;
        addr_t a;
        int    len;
        int    nrec;
        int    cycles0;
        HCLK      = 1'b0;
        rst_n     = 1'b0;
        haddr     = '0;
        htrans    = `HTRANS_IDLE;
        hwrite    = 1'b0;
        hsize     = `HSIZE_WORD;
        hwdata    = '0;
        uart_rx   = 1'b1;
        lcg_state = 32'h782f;
        errors    = 0;
        exp_en    = 1'b1;
        exp_fmt   = 1'b0;
        exp_cks   = 1'b0;
        exp_loc   = '0;
        repeat (2) @(posedge HCLK);
        rst_n <= 1'b1;
        @(negedge HCLK);
        check(soc_reset, 1'b0, "soc_reset after reset");
        check_status("status after reset");
        for (int w = 0; w < `LOADER_RAM_WORDS; w++) begin
            store_word(addr_t'(w * 4), fill_word(addr_t'(w * 4)));
        end

        // Random S3 load closed by S7
        random_load(5);
        check_status("status after S3 load");
        verify_ram("S3 load");

        // S0 header then S1 records closed by S9
        load_started();
        random_data(4);
        build_record("0", 32'h0, 4, 1'b0, -1);
        send_line(0);
        good_records("1", 3);
        build_record("9", 32'h0, 0, 1'b0, -1);
        send_line(0);
        wait_soc_reset(1'b0, "end of S1 load");
        check_status("status after S1 load");
        verify_ram("S1 load");

        // Bad checksum record is still written
        nrec = 1 + int'(next_rand() % 3);
        load_started();
        good_records("3", nrec);
        len = 1 + int'(next_rand() % 16);
        random_data(len);
        build_record("3", random_addr(len), len, 1'b1, -1);
        send_line(0);
        wait_soc_reset(1'b0, "checksum error");
        exp_cks = 1'b1;
        exp_loc = byte_t'(nrec);
        check_status("status after checksum error");
        verify_ram("checksum error");

        // Non-hex digit in the data field
        nrec = 1 + int'(next_rand() % 3);
        load_started();
        good_records("3", nrec);
        len = 1 + int'(next_rand() % 16);
        random_data(len);
        build_record("3", random_addr(len), len, 1'b0, 12 + int'(next_rand() % (2 * len)));
        send_line(0);
        wait_soc_reset(1'b0, "format error");
        exp_fmt = 1'b1;
        exp_loc = byte_t'(nrec);
        check_status("status after format error");
        verify_ram("format error");
        random_load(2);
        check_status("status after recovery load");
        verify_ram("recovery load");

        // External master is shut out during a load
        load_started();
        random_data(4);
        build_record("3", random_addr(4), 4, 1'b0, -1);
        send_char(line_q[0]);
        wait_soc_reset(1'b1, "load start");
        ahb_write(addr_t'(next_rand() % 1024) << 2, next_rand(), `HSIZE_WORD);
        send_line(1);
        build_record("7", 32'h0, 0, 1'b0, -1);
        send_line(0);
        wait_soc_reset(1'b0, "end of load");
        a = random_addr(1);
        d = data_t'(next_rand() & 32'hff);
        ahb_write(a, d << {a[1:0], 3'b000}, `HSIZE_BYTE);
        model_mem[int'(a)] = byte_t'(d);
        store_word(addr_t'(next_rand() % 1024) << 2, next_rand());
        check_status("status after blocked writes");
        verify_ram("external writes");

        // Loader disabled through bit 16
        ahb_write(`LOADER_STATUS_BASE, 32'h0, `HSIZE_WORD);
        exp_en  = 1'b0;
        cycles0 = reset_cycles;
        check_status("status with loader disabled");
        good_records("3", 1);
        build_record("7", 32'h0, 0, 1'b0, -1);
        send_line(0);
        repeat (4) @(posedge HCLK);
        check(reset_cycles - cycles0, 0, "soc_reset cycles while disabled");
        check_status("status after ignored record");
        verify_ram("loader disabled");
        ahb_write(`LOADER_STATUS_BASE, 32'h0001_0000, `HSIZE_WORD);
        exp_en = 1'b1;
        random_load(2);
        check_status("status after re-enable");
        verify_ram("loader re-enabled");

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
loader_pkg.sv
uart_receiver.sv
srec_parser.sv
ahb_matrix.sv
ahb_ram.sv
loader_status_regs.sv
soc_top.sv
tb_soc_top.sv

// File: Makefile
# Verilator build and run of the loader subsystem testbench

all: run

obj_dir/Vtb_soc_top: filelist.f *.sv *.svh
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_soc_top

run: obj_dir/Vtb_soc_top
	./obj_dir/Vtb_soc_top | tee run.log
	grep -q "Verification passed" run.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module soc_top

clean:
	rm -rf obj_dir run.log

.PHONY: all run lint clean
